/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal -j 0
TOP      = edge_job_control_tb
FILELIST = project.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)

/* hdl/cacheline_stream.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheline_stream (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 beat_valid,
	input  mem_pkg::read_beat_t                  beat,
	output logic                                 empty,
	output logic                                 word_valid,
	output logic [graph_pkg::EDGE_WORD_BITS-1:0] word,
	input  logic                                 pop
);

	import graph_pkg::*;
	import mem_pkg::*;

	// line kept as words so the current one can be picked by position
	logic [LINE_WORDS-1:0][EDGE_WORD_BITS-1:0] line;

	logic [WORD_IDX_BITS-1:0] pos;
	logic [WORD_IDX_BITS:0]   count;

	////////////////////////////////////////
	// load and shift
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pos   <= '0;
			count <= '0;
		end else if (beat_valid) begin
			pos <= beat.offset;
			// beat count of 0 is a whole line
			if (beat.count == '0) begin
				count <= (WORD_IDX_BITS+1)'(LINE_WORDS);
			end else begin
				count <= {1'b0, beat.count};
			end
		end else if (pop) begin
			pos   <= pos + 1'b1;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (beat_valid) begin
			line <= beat.data;
		end
	end

	assign empty      = (count == '0);
	assign word_valid = !empty;
	assign word       = line[pos];

	// top level only routes a beat here once the last line is used up
	beat_into_empty: assert property (@(posedge clock) disable iff (!rstn)
		beat_valid |-> empty);

	// the assembler never pops a word that is not there
	pop_with_word: assert property (@(posedge clock) disable iff (!rstn)
		pop |-> word_valid);

endmodule

`default_nettype wire

/* hdl/edge_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_assembler (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 src_valid,
	input  logic [graph_pkg::EDGE_WORD_BITS-1:0] src_word,
	input  logic                                 dest_valid,
	input  logic [graph_pkg::EDGE_WORD_BITS-1:0] dest_word,
	input  logic                                 weight_valid,
	input  logic [graph_pkg::EDGE_WORD_BITS-1:0] weight_word,
	input  logic                                 fifo_full,
	output logic                                 pop,
	output logic                                 push,
	output graph_pkg::edge_job_t                 edge_out
);

	import graph_pkg::*;

	logic [EDGE_ID_BITS-1:0] next_id;

	// full lags a pending write by one cycle, so skip the cycle of a push
	assign pop = src_valid && dest_valid && weight_valid && !fifo_full && !push;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push    <= 1'b0;
			next_id <= '0;
		end else begin
			push <= pop;
			if (pop) begin
				next_id <= next_id + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			edge_out.id     <= next_id;
			edge_out.src    <= src_word;
			edge_out.dest   <= dest_word;
			edge_out.weight <= weight_word;
		end
	end

	// the three streams hold the same chunk and drain in lockstep
	words_agree: assert property (@(posedge clock) disable iff (!rstn)
		pop |=> (src_valid == dest_valid) && (dest_valid == weight_valid));

endmodule

`default_nettype wire

/* hdl/edge_job_control.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_job_control #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  graph_pkg::graph_layout_t layout,
	input  logic                     vertex_job_valid,
	output logic                     vertex_job_ready,
	input  graph_pkg::vertex_job_t   vertex_job,
	output logic                     read_cmd_valid,
	input  logic                     read_cmd_ready,
	output mem_pkg::read_cmd_t       read_cmd,
	input  logic                     read_beat_valid,
	output logic                     read_beat_ready,
	input  mem_pkg::read_beat_t      read_beat,
	output logic                     edge_job_valid,
	input  logic                     edge_job_ready,
	output graph_pkg::edge_job_t     edge_job
);

	import graph_pkg::*;
	import mem_pkg::*;

	logic beat_accepted;
	logic streams_empty;
	logic src_empty, dest_empty, weight_empty;
	logic src_valid, dest_valid, weight_valid;
	logic [EDGE_WORD_BITS-1:0] src_word, dest_word, weight_word;
	logic      word_pop;
	logic      fifo_push;
	logic      fifo_full;
	edge_job_t assembled;

	////////////////////////////////////////
	// beat routing
	////////////////////////////////////////

	// a beat is taken only when its own stream has room
	assign read_beat_ready =
		(read_beat.sel == ARRAY_SRC)    ? src_empty :
		(read_beat.sel == ARRAY_DEST)   ? dest_empty :
		(read_beat.sel == ARRAY_WEIGHT) ? weight_empty : 1'b0;

	assign beat_accepted = read_beat_valid && read_beat_ready;
	assign streams_empty = src_empty && dest_empty && weight_empty;

	edge_read_scheduler u_scheduler (
		.clock            (clock),
		.rstn             (rstn),
		.layout           (layout),
		.vertex_job_valid (vertex_job_valid),
		.vertex_job_ready (vertex_job_ready),
		.vertex_job       (vertex_job),
		.read_cmd_valid   (read_cmd_valid),
		.read_cmd_ready   (read_cmd_ready),
		.read_cmd         (read_cmd),
		.beat_accepted    (beat_accepted),
		.streams_empty    (streams_empty)
	);

	cacheline_stream u_src_stream (
		.clock      (clock),
		.rstn       (rstn),
		.beat_valid (beat_accepted && (read_beat.sel == ARRAY_SRC)),
		.beat       (read_beat),
		.empty      (src_empty),
		.word_valid (src_valid),
		.word       (src_word),
		.pop        (word_pop)
	);

	cacheline_stream u_dest_stream (
		.clock      (clock),
		.rstn       (rstn),
		.beat_valid (beat_accepted && (read_beat.sel == ARRAY_DEST)),
		.beat       (read_beat),
		.empty      (dest_empty),
		.word_valid (dest_valid),
		.word       (dest_word),
		.pop        (word_pop)
	);

	cacheline_stream u_weight_stream (
		.clock      (clock),
		.rstn       (rstn),
		.beat_valid (beat_accepted && (read_beat.sel == ARRAY_WEIGHT)),
		.beat       (read_beat),
		.empty      (weight_empty),
		.word_valid (weight_valid),
		.word       (weight_word),
		.pop        (word_pop)
	);

	////////////////////////////////////////
	// edge assembly and output buffer
	////////////////////////////////////////

	edge_assembler u_assembler (
		.clock        (clock),
		.rstn         (rstn),
		.src_valid    (src_valid),
		.src_word     (src_word),
		.dest_valid   (dest_valid),
		.dest_word    (dest_word),
		.weight_valid (weight_valid),
		.weight_word  (weight_word),
		.fifo_full    (fifo_full),
		.pop          (word_pop),
		.push         (fifo_push),
		.edge_out     (assembled)
	);

	sync_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_edge_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (fifo_push),
		.data_in  (assembled),
		.full     (fifo_full),
		.valid    (edge_job_valid),
		.ready    (edge_job_ready),
		.data_out (edge_job)
	);

endmodule

`default_nettype wire

/* hdl/edge_read_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_read_scheduler (
	input  logic                     clock,
	input  logic                     rstn,
	input  graph_pkg::graph_layout_t layout,
	input  logic                     vertex_job_valid,
	output logic                     vertex_job_ready,
	input  graph_pkg::vertex_job_t   vertex_job,
	output logic                     read_cmd_valid,
	input  logic                     read_cmd_ready,
	output mem_pkg::read_cmd_t       read_cmd,
	input  logic                     beat_accepted,
	input  logic                     streams_empty
);

	import graph_pkg::*;
	import mem_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		CALC,
		ISSUE_SRC,
		ISSUE_DEST,
		ISSUE_WEIGHT,
		DRAIN
	} sched_state_e;

	sched_state_e state, next_state;

	logic [EDGE_ID_BITS-1:0]  remaining;
	logic [ADDR_BITS-1:0]     next_index;
	logic [2:0]               outstanding;

	// chunk currently being issued
	logic [ADDR_BITS-1:0]     chunk_bytes;
	logic [WORD_IDX_BITS-1:0] chunk_offset;
	logic [WORD_IDX_BITS:0]   chunk_words;

	logic [ADDR_BITS-1:0]     index_bytes;
	logic [WORD_IDX_BITS-1:0] calc_offset;
	logic [WORD_IDX_BITS:0]   line_room;
	logic [WORD_IDX_BITS:0]   calc_words;
	logic                     chunk_go;
	logic                     cmd_fire;
	logic                     vertex_fire;

	////////////////////////////////////////
	// chunk calculation
	////////////////////////////////////////

	// offset comes from the index alone since bases are line aligned
	assign index_bytes = next_index << $clog2(WORD_BYTES);
	assign calc_offset = index_bytes[$clog2(LINE_BYTES)-1:$clog2(WORD_BYTES)];
	assign line_room   = (WORD_IDX_BITS+1)'(LINE_WORDS) - {1'b0, calc_offset};
	assign calc_words  = (remaining < EDGE_ID_BITS'(line_room)) ?
		remaining[WORD_IDX_BITS:0] : line_room;

	// a new chunk waits for every earlier line to be consumed
	assign chunk_go    = (state == CALC) && (outstanding == '0) && streams_empty;
	assign cmd_fire    = read_cmd_valid && read_cmd_ready;
	assign vertex_fire = vertex_job_valid && vertex_job_ready;

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE:         if (vertex_job_valid) next_state = CALC;
			CALC:         if (chunk_go) next_state = ISSUE_SRC;
			ISSUE_SRC:    if (read_cmd_ready) next_state = ISSUE_DEST;
			ISSUE_DEST:   if (read_cmd_ready) next_state = ISSUE_WEIGHT;
			ISSUE_WEIGHT: begin
				if (read_cmd_ready) begin
					next_state = (remaining == '0) ? DRAIN : CALC;
				end
			end
			DRAIN:        if ((outstanding == '0) && streams_empty) next_state = IDLE;
			default:      next_state = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= IDLE;
			remaining   <= '0;
			next_index  <= '0;
			outstanding <= '0;
		end else begin
			state <= next_state;
			if (vertex_fire) begin
				remaining  <= vertex_job.edge_count;
				next_index <= vertex_job.first_index;
			end else if (chunk_go) begin
				remaining  <= remaining - EDGE_ID_BITS'(calc_words);
				next_index <= next_index + ADDR_BITS'(calc_words);
			end
			// reads in flight, a command and a beat may cross in one cycle
			case ({cmd_fire, beat_accepted})
				2'b10:   outstanding <= outstanding + 3'd1;
				2'b01:   outstanding <= outstanding - 3'd1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (chunk_go) begin
			chunk_bytes  <= index_bytes;
			chunk_offset <= calc_offset;
			chunk_words  <= calc_words;
		end
	end

	////////////////////////////////////////
	// command and vertex handshakes
	////////////////////////////////////////

	assign vertex_job_ready = (state == IDLE);
	assign read_cmd_valid   = (state == ISSUE_SRC) || (state == ISSUE_DEST) ||
		(state == ISSUE_WEIGHT);

	always_comb begin
		read_cmd.offset = chunk_offset;
		// a full line of 4 wraps to 0
		read_cmd.count  = chunk_words[WORD_IDX_BITS-1:0];
		case (state)
			ISSUE_DEST: begin
				read_cmd.sel  = ARRAY_DEST;
				read_cmd.addr = (layout.dest_base + chunk_bytes) & LINE_MASK;
			end
			ISSUE_WEIGHT: begin
				read_cmd.sel  = ARRAY_WEIGHT;
				read_cmd.addr = (layout.weight_base + chunk_bytes) & LINE_MASK;
			end
			default: begin
				read_cmd.sel  = ARRAY_SRC;
				read_cmd.addr = (layout.src_base + chunk_bytes) & LINE_MASK;
			end
		endcase
	end

	// command must hold until the memory side takes it
	cmd_stable_check: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid && !read_cmd_ready |=> read_cmd_valid && $stable(read_cmd));

endmodule

`default_nettype wire

/* hdl/graph_pkg.sv */
`default_nettype none

package graph_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// one element of the src, dest or weight array
	localparam int EDGE_WORD_BITS = 32;

	// byte addresses and edge indices
	localparam int ADDR_BITS = 32;

	// edge ids and per-vertex edge counts
	localparam int EDGE_ID_BITS = 16;

	////////////////////////////////////////
	// job and layout types
	////////////////////////////////////////

	// one vertex worth of edges, zero edges is not allowed
	typedef struct packed {
		logic [ADDR_BITS-1:0]    first_index;
		logic [EDGE_ID_BITS-1:0] edge_count;
	} vertex_job_t;

	// one assembled edge, id runs across vertices
	typedef struct packed {
		logic [EDGE_ID_BITS-1:0]   id;
		logic [EDGE_WORD_BITS-1:0] src;
		logic [EDGE_WORD_BITS-1:0] dest;
		logic [EDGE_WORD_BITS-1:0] weight;
	} edge_job_t;

	// byte base of each edge array, expected cacheline aligned
	typedef struct packed {
		logic [ADDR_BITS-1:0] src_base;
		logic [ADDR_BITS-1:0] dest_base;
		logic [ADDR_BITS-1:0] weight_base;
	} graph_layout_t;

endpackage

`default_nettype wire

/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	////////////////////////////////////////
	// cacheline geometry
	////////////////////////////////////////

	localparam int LINE_WORDS = 4;
	localparam int WORD_BYTES = 4;
	localparam int LINE_BYTES = LINE_WORDS * WORD_BYTES;
	localparam int LINE_BITS  = LINE_BYTES * 8;

	// word position inside a line
	localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);

	// clears the byte-in-line bits of an address
	localparam logic [graph_pkg::ADDR_BITS-1:0] LINE_MASK =
		~(graph_pkg::ADDR_BITS'(LINE_BYTES - 1));

	////////////////////////////////////////
	// read command and returned data
	////////////////////////////////////////

	// which edge array a command or beat belongs to
	typedef enum logic [1:0] {
		ARRAY_SRC    = 2'd0,
		ARRAY_DEST   = 2'd1,
		ARRAY_WEIGHT = 2'd2
	} array_sel_e;

	// count of 0 stands for a full line of 4 words
	typedef struct packed {
		array_sel_e                      sel;
		logic [graph_pkg::ADDR_BITS-1:0] addr;
		logic [WORD_IDX_BITS-1:0]        offset;
		logic [WORD_IDX_BITS-1:0]        count;
	} read_cmd_t;

	// memory echoes sel, offset and count back with the line
	// word k of the line sits at data[k*32 +: 32]
	typedef struct packed {
		array_sel_e               sel;
		logic [WORD_IDX_BITS-1:0] offset;
		logic [WORD_IDX_BITS-1:0] count;
		logic [LINE_BITS-1:0]     data;
	} read_beat_t;

endpackage

`default_nettype wire

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 push,
	input  graph_pkg::edge_job_t data_in,
	output logic                 full,
	output logic                 valid,
	input  logic                 ready,
	output graph_pkg::edge_job_t data_out
);

	import graph_pkg::*;

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);

	edge_job_t mem [FIFO_DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;
	logic                read_fire;

	assign read_fire = valid && ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap on their own for a power of two depth
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (read_fire) rd_ptr <= rd_ptr + 1'b1;
			case ({push, read_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	assign full     = (count == (PTR_BITS+1)'(FIFO_DEPTH));
	assign valid    = (count != '0);
	assign data_out = mem[rd_ptr];

	// the producer must respect full
	no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		push |-> !full);

endmodule

`default_nettype wire

/* project.f */
hdl/graph_pkg.sv
hdl/mem_pkg.sv
hdl/edge_read_scheduler.sv
hdl/cacheline_stream.sv
hdl/edge_assembler.sv
hdl/sync_fifo.sv
hdl/edge_job_control.sv
verification/edge_job_control_tb.sv

/* verification/edge_job_control_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_job_control_tb;

	import graph_pkg::*;
	import mem_pkg::*;

	localparam int NUM_TESTS = 5;

	////////////////////////////////////////
	// test table
	////////////////////////////////////////

	string test_name  [NUM_TESTS] = '{"aligned", "misaligned", "short", "backpressure", "tail"};
	int    test_index [NUM_TESTS] = '{8, 3, 20, 26, 61};
	int    test_edges [NUM_TESTS] = '{8, 6, 2, 12, 5};
	// percent of cycles with edge_job_ready high
	int    ready_pct  [NUM_TESTS] = '{100, 100, 100, 50, 80};

	logic          clock;
	logic          rstn;
	graph_layout_t layout;
	logic          vertex_job_valid;
	logic          vertex_job_ready;
	vertex_job_t   vertex_job;
	logic          read_cmd_valid;
	logic          read_cmd_ready;
	read_cmd_t     read_cmd;
	logic          read_beat_valid;
	logic          read_beat_ready;
	read_beat_t    read_beat;
	logic          edge_job_valid;
	logic          edge_job_ready;
	edge_job_t     edge_job;

	integer seed;
	int     errors;
	int     test_errors [NUM_TESTS];
	int     cmd_total [NUM_TESTS];
	int     cycle;
	int     out_test;
	int     out_seen;
	int     accept_idx;
	int     cmds_left;
	int     wait_cycles;

	// expected commands and edges in arrival order
	read_cmd_t exp_cmd_q [$];
	int        exp_cmd_test [$];
	edge_job_t exp_edge_q [$];

	// commands taken by the memory model and not yet answered
	read_cmd_t pend_q [$];
	int        due_q [$];

	edge_job_control #(
		.FIFO_DEPTH (8)
	) u_edge_job_control (
		.clock            (clock),
		.rstn             (rstn),
		.layout           (layout),
		.vertex_job_valid (vertex_job_valid),
		.vertex_job_ready (vertex_job_ready),
		.vertex_job       (vertex_job),
		.read_cmd_valid   (read_cmd_valid),
		.read_cmd_ready   (read_cmd_ready),
		.read_cmd         (read_cmd),
		.read_beat_valid  (read_beat_valid),
		.read_beat_ready  (read_beat_ready),
		.read_beat        (read_beat),
		.edge_job_valid   (edge_job_valid),
		.edge_job_ready   (edge_job_ready),
		.edge_job         (edge_job)
	);

	always #50 clock = ~clock;

	////////////////////////////////////////
	// memory contents and expected values
	////////////////////////////////////////

	function automatic logic [EDGE_WORD_BITS-1:0] array_word(array_sel_e sel, int unsigned i);
		case (sel)
			ARRAY_SRC:  return i * 3 + 1;
			ARRAY_DEST: return i ^ 32'h5a5a;
			default:    return i + 1000;
		endcase
	endfunction

	function automatic logic [ADDR_BITS-1:0] array_base(array_sel_e sel);
		case (sel)
			ARRAY_SRC:  return layout.src_base;
			ARRAY_DEST: return layout.dest_base;
			default:    return layout.weight_base;
		endcase
	endfunction

	function automatic read_beat_t make_beat(read_cmd_t cmd);
		read_beat_t  beat;
		int unsigned first;
		beat.sel    = cmd.sel;
		beat.offset = cmd.offset;
		beat.count  = cmd.count;
		first = (cmd.addr - array_base(cmd.sel)) / WORD_BYTES;
		for (int k = 0; k < LINE_WORDS; k++) begin
			beat.data[k*EDGE_WORD_BITS +: EDGE_WORD_BITS] = array_word(cmd.sel, first + k);
		end
		return beat;
	endfunction

	task automatic build_expected();
		int unsigned index;
		int unsigned remaining;
		int unsigned addr;
		int unsigned offset;
		int unsigned words;
		int          id;
		read_cmd_t   cmd;
		edge_job_t   ej;
		id = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			index        = test_index[t];
			remaining    = test_edges[t];
			cmd_total[t] = 0;
			while (remaining > 0) begin
				addr   = layout.src_base + index * WORD_BYTES;
				offset = (addr % LINE_BYTES) / WORD_BYTES;
				words  = (remaining < LINE_WORDS - offset) ? remaining : LINE_WORDS - offset;
				// src, dest, weight per chunk
				for (int a = 0; a < 3; a++) begin
					cmd.sel    = array_sel_e'(a);
					addr       = array_base(cmd.sel) + index * WORD_BYTES;
					cmd.addr   = addr & 32'hffff_fff0;
					cmd.offset = 2'((addr % LINE_BYTES) / WORD_BYTES);
					// a full line of 4 is coded as 0
					cmd.count  = 2'(words);
					exp_cmd_q.push_back(cmd);
					exp_cmd_test.push_back(t);
					cmd_total[t]++;
				end
				index     = index + words;
				remaining = remaining - words;
			end
			// ids keep counting across vertices
			for (int e = 0; e < test_edges[t]; e++) begin
				ej.id     = 16'(id);
				ej.src    = array_word(ARRAY_SRC, test_index[t] + e);
				ej.dest   = array_word(ARRAY_DEST, test_index[t] + e);
				ej.weight = array_word(ARRAY_WEIGHT, test_index[t] + e);
				exp_edge_q.push_back(ej);
				id++;
			end
		end
	endtask

	////////////////////////////////////////
	// checks and reporting
	////////////////////////////////////////

	task automatic note_error(int t);
		errors++;
		if (t >= 0 && t < NUM_TESTS) begin
			test_errors[t]++;
		end
	endtask

	task automatic report_test(int t);
		if (test_errors[t] == 0) begin
			$display("test %0d %s: passed, %0d edges", t, test_name[t], test_edges[t]);
		end else begin
			$display("test %0d %s: failed with %0d errors", t, test_name[t], test_errors[t]);
		end
	endtask

	task automatic check_command(read_cmd_t cmd);
		int t;
		if (exp_cmd_q.size() == 0) begin
			$display("read command %h arrived when no more commands were expected", cmd);
			note_error(-1);
		end else begin
			t = exp_cmd_test.pop_front();
			if (cmd !== exp_cmd_q[0]) begin
				$display("Mismatch %s read command: expected %h, actual %h",
					test_name[t], exp_cmd_q[0], cmd);
				note_error(t);
			end
			void'(exp_cmd_q.pop_front());
		end
	endtask

	task automatic check_edge(edge_job_t ej);
		if (exp_edge_q.size() == 0 || out_test >= NUM_TESTS) begin
			$display("edge job %h arrived after all expected edges", ej);
			note_error(-1);
		end else begin
			if (ej !== exp_edge_q[0]) begin
				$display("Mismatch %s edge %0d: expected %h, actual %h",
					test_name[out_test], out_seen, exp_edge_q[0], ej);
				note_error(out_test);
			end
			void'(exp_edge_q.pop_front());
			out_seen++;
			if (out_seen == test_edges[out_test]) begin
				report_test(out_test);
				out_test++;
				out_seen = 0;
			end
		end
	endtask

	////////////////////////////////////////
	// memory model and edge sink
	////////////////////////////////////////

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (rstn) begin
			if (read_cmd_valid && read_cmd_ready) begin
				check_command(read_cmd);
				pend_q.push_back(read_cmd);
				due_q.push_back(cycle + ({$random(seed)} % 4));
			end
			if (read_beat_valid && read_beat_ready) begin
				void'(pend_q.pop_front());
				void'(due_q.pop_front());
			end
			if (edge_job_valid && edge_job_ready) begin
				check_edge(edge_job);
			end
		end
		#1;
		read_cmd_ready = ({$random(seed)} % 4) != 0;
		read_beat_valid = 1'b0;
		if (pend_q.size() > 0) begin
			if (due_q[0] <= cycle) begin
				read_beat_valid = 1'b1;
				read_beat       = make_beat(pend_q[0]);
			end
		end
		if (out_test < NUM_TESTS) begin
			edge_job_ready = ({$random(seed)} % 100) < ready_pct[out_test];
		end else begin
			edge_job_ready = 1'b1;
		end
	end

	// vertex_job_ready stays low while the last vertex has reads to issue or answer
	always @(posedge clock) begin
		if (rstn) begin
			if (vertex_job_ready && (cmds_left != 0 || pend_q.size() != 0)) begin
				$display("vertex_job_ready went high while vertex %0d still had reads in flight",
					accept_idx - 1);
				note_error(accept_idx - 1);
			end
			if (vertex_job_valid && !vertex_job_ready) begin
				wait_cycles++;
			end
			if (read_cmd_valid && read_cmd_ready && cmds_left > 0) begin
				cmds_left--;
			end
			if (vertex_job_valid && vertex_job_ready && accept_idx < NUM_TESTS) begin
				cmds_left = cmd_total[accept_idx];
				accept_idx++;
			end
		end
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int passed;
		seed                 = 32'haa54;
		clock                = 1'b0;
		rstn                 = 1'b0;
		layout.src_base      = 32'h0001_0000;
		layout.dest_base     = 32'h0002_0000;
		layout.weight_base   = 32'h0003_0000;
		vertex_job_valid     = 1'b0;
		vertex_job           = '0;
		read_cmd_ready       = 1'b0;
		read_beat_valid      = 1'b0;
		read_beat            = '0;
		edge_job_ready       = 1'b0;
		errors      = 0;
		cycle       = 0;
		out_test    = 0;
		out_seen    = 0;
		accept_idx  = 0;
		cmds_left   = 0;
		wait_cycles = 0;
		foreach (test_errors[t]) begin
			test_errors[t] = 0;
		end
		build_expected();

		repeat (8) @(posedge clock);
		#1;
		rstn = 1'b1;
		if (vertex_job_ready !== 1'b1 || read_cmd_valid !== 1'b0 || edge_job_valid !== 1'b0) begin
			$display("handshake outputs are not at their idle levels after reset");
			note_error(-1);
		end

		// each vertex waits until the previous one is done
		for (int t = 0; t < NUM_TESTS; t++) begin
			vertex_job_valid       = 1'b1;
			vertex_job.first_index = test_index[t];
			vertex_job.edge_count  = 16'(test_edges[t]);
			@(posedge clock);
			while (!vertex_job_ready) @(posedge clock);
			#1;
		end
		vertex_job_valid = 1'b0;
		vertex_job       = '0;

		while (out_test < NUM_TESTS) @(posedge clock);
		repeat (4) @(posedge clock);

		if (exp_cmd_q.size() != 0 || pend_q.size() != 0) begin
			$display("%0d read commands were never issued and %0d were never answered",
				exp_cmd_q.size(), pend_q.size());
			note_error(-1);
		end
		if (wait_cycles == 0) begin
			$display("no vertex ever had to wait while another was in progress");
			note_error(-1);
		end

		passed = 0;
		foreach (test_errors[t]) begin
			if (test_errors[t] == 0) passed++;
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors in total",
			NUM_TESTS, passed, NUM_TESTS - passed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog sized from the total edge count
	initial begin
		int limit;
		limit = 500;
		foreach (test_edges[t]) begin
			limit = limit + test_edges[t] * 60;
		end
		repeat (limit) @(posedge clock);
		$display("run did not finish within %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
